// File: design/sdram_fb_pkg.sv
package sdram_fb_pkg;

    // sdram geometry
    localparam int row_w  = 12;
    localparam int col_w  = 8;
    localparam int bank_w = 2;
    localparam int data_w = 16;

    // fixed mode register settings
    localparam int burst_len = 8;
    localparam int cas_lat   = 2;

    // {bank, row, col}, the top bit picks the frame buffer
    typedef logic [bank_w+row_w+col_w-1:0] addr_t;

    typedef enum logic [1:0] {
        cmd_idle    = 2'd0,
        cmd_write   = 2'd1,
        cmd_read    = 2'd2,
        cmd_refresh = 2'd3
    } ctrl_cmd_e;

    typedef enum logic [3:0] {
        init_wait,
        init_pre,
        init_ref,
        init_mrs,
        idle,
        activate,
        rcd_wait,
        write_burst,
        read_burst,
        precharge,
        refresh,
        ack
    } seq_state_e;

endpackage

// File: design/sdram_cmd_if.sv
`timescale 1ns/1ns

interface sdram_cmd_if;
    import sdram_fb_pkg::*;

    // held by the controller until ack
    ctrl_cmd_e cmd;
    addr_t     addr;

    // one cycle pulse at the end of tRP
    logic      ack;
    logic      init_done;

    modport ctrl (
        output cmd,
        output addr,
        input  ack,
        input  init_done
    );

    modport seq (
        input  cmd,
        input  addr,
        output ack,
        output init_done
    );

endinterface

// File: design/sdram_fifo.sv
`timescale 1ns/1ns

module sdram_fifo #(
    parameter int depth = 1024
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wr,
    input  logic [sdram_fb_pkg::data_w-1:0]  wdata,
    input  logic                             rd,
    output logic [sdram_fb_pkg::data_w-1:0]  rdata,
    output logic [$clog2(depth+1)-1:0]       count
);
    import sdram_fb_pkg::*;

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    logic [data_w-1:0] mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic              do_wr;
    logic              do_rd;

    // a write into a full buffer is dropped
    assign do_wr = wr && (count != cnt_w'(depth));
    assign do_rd = rd && (count != '0);

    // show-ahead, head word sits on rdata before rd
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr && count == cnt_w'(depth)));

    no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd && count == '0));

endmodule

// File: design/sdram_ctrl.sv
`timescale 1ns/1ns

module sdram_ctrl #(
    parameter int refresh_cycles = 780
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                w_req,
    input  logic                r_req,
    input  sdram_fb_pkg::addr_t wr_addr,
    output logic                req_ack,
    output logic                busy,
    sdram_cmd_if.ctrl           cmd_if
);
    import sdram_fb_pkg::*;

    // one cycle short of the interval, since a burst in flight plus the
    // idle cycle after its ack can hold a refresh back by 17 cycles
    localparam int ref_period = refresh_cycles - 1;
    localparam int ref_w      = $clog2(ref_period);

    logic [ref_w-1:0] ref_cnt;
    logic             ref_wrap;
    logic             ref_pending;
    logic             cmd_free;
    logic             grant_ref;
    logic             grant_data;

    // ----------------------------------------------------------
    // arbitration, refresh > read > write
    // ----------------------------------------------------------
    assign cmd_free   = cmd_if.init_done && (cmd_if.cmd == cmd_idle);
    assign grant_ref  = cmd_free && ref_pending;
    assign grant_data = cmd_free && !ref_pending && (r_req || w_req);

    assign ref_wrap = cmd_if.init_done && (ref_cnt == ref_w'(ref_period - 1));

    assign busy    = (cmd_if.cmd != cmd_idle) || ref_pending;
    assign req_ack = cmd_if.ack && (cmd_if.cmd == cmd_write || cmd_if.cmd == cmd_read);

    // refresh interval, starts once init is over
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_cnt     <= '0;
            ref_pending <= 1'b0;
        end else begin
            if (!cmd_if.init_done || ref_wrap) begin
                ref_cnt <= '0;
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
            end
            ref_pending <= ref_wrap || (ref_pending && !grant_ref);
        end
    end

    // command held until the sequencer acks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_if.cmd <= cmd_idle;
        end else if (grant_ref) begin
            cmd_if.cmd <= cmd_refresh;
        end else if (grant_data) begin
            cmd_if.cmd <= r_req ? cmd_read : cmd_write;
        end else if (cmd_if.ack) begin
            cmd_if.cmd <= cmd_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_data) begin
            cmd_if.addr <= wr_addr;
        end
    end

    // a due refresh waits at most for one data command
    ref_served: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ref_pending) |-> ##[1:24] !ref_pending);

endmodule

// File: design/sdram_cmd.sv
`timescale 1ns/1ns

module sdram_cmd #(
    parameter int init_cycles = 20000
) (
    input  logic                             clk,
    input  logic                             rst_n,
    sdram_cmd_if.seq                         cmd_if,
    output logic                             w_fifo_rd,
    output logic                             r_fifo_wr,
    output logic                             dq_oe,
    output logic                             cke,
    output logic                             cs_n,
    output logic                             ras_n,
    output logic                             cas_n,
    output logic                             we_n,
    output logic [sdram_fb_pkg::bank_w-1:0]  ba,
    output logic [sdram_fb_pkg::row_w-1:0]   a
);
    import sdram_fb_pkg::*;

    localparam int cnt_w = ($clog2(init_cycles) > 4) ? $clog2(init_cycles) : 4;

    // sequential burst of 8, cas 2, burst write
    localparam logic [row_w-1:0] mode_word =
        {{(row_w-7){1'b0}}, 3'(cas_lat), 1'b0, 3'($clog2(burst_len))};

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        pin_mrs = 4'b0000,
        pin_ref = 4'b0001,
        pin_pre = 4'b0010,
        pin_act = 4'b0011,
        pin_wr  = 4'b0100,
        pin_rd  = 4'b0101,
        pin_nop = 4'b0111
    } pin_cmd_e;

    seq_state_e        state;
    seq_state_e        next_state;
    logic [cnt_w-1:0]  cnt;
    logic [cnt_w-1:0]  last_cnt;
    pin_cmd_e          pin_cmd;
    logic [bank_w-1:0] cur_bank;
    logic [row_w-1:0]  cur_row;
    logic [row_w-1:0]  col_word;

    assign cur_bank = cmd_if.addr[col_w+row_w +: bank_w];
    assign cur_row  = cmd_if.addr[col_w +: row_w];
    // upper bits zero, so A10 stays low and no auto-precharge
    assign col_word = {{(row_w-col_w){1'b0}}, cmd_if.addr[col_w-1:0]};

    // ----------------------------------------------------------
    // state lengths and successors
    // ----------------------------------------------------------
    always_comb begin
        last_cnt   = '0;
        next_state = state;
        case (state)
            init_wait: begin
                last_cnt   = cnt_w'(init_cycles - 1);
                next_state = init_pre;
            end
            init_pre: begin
                last_cnt   = cnt_w'(1);
                next_state = init_ref;
            end
            init_ref: begin
                last_cnt   = cnt_w'(7);
                next_state = init_mrs;
            end
            init_mrs: begin
                last_cnt   = cnt_w'(3);
                next_state = idle;
            end
            idle: begin
                if (cmd_if.cmd == cmd_refresh) begin
                    next_state = refresh;
                end else if (cmd_if.cmd != cmd_idle) begin
                    next_state = activate;
                end
            end
            activate:    next_state = rcd_wait;
            rcd_wait: begin
                last_cnt   = cnt_w'(1);
                next_state = (cmd_if.cmd == cmd_read) ? read_burst : write_burst;
            end
            write_burst: begin
                last_cnt   = cnt_w'(burst_len - 1);
                next_state = precharge;
            end
            // read cmd, cas wait, then the data beats
            read_burst: begin
                last_cnt   = cnt_w'(cas_lat + burst_len - 1);
                next_state = precharge;
            end
            precharge: begin
                last_cnt   = cnt_w'(1);
                next_state = ack;
            end
            refresh: begin
                last_cnt   = cnt_w'(6);
                next_state = ack;
            end
            default:     next_state = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= init_wait;
            cnt              <= '0;
            cmd_if.init_done <= 1'b0;
        end else if (cnt == last_cnt) begin
            state <= next_state;
            cnt   <= '0;
            if (state == init_mrs) begin
                cmd_if.init_done <= 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // pin decode
    // ----------------------------------------------------------
    always_comb begin
        pin_cmd = pin_nop;
        ba      = '0;
        a       = '0;
        case (state)
            init_pre, precharge: begin
                if (cnt == '0) begin
                    pin_cmd = pin_pre;
                    a[10]   = 1'b1;
                end
            end
            // two refreshes, four cycles apart
            init_ref: begin
                if (cnt[1:0] == 2'd0) begin
                    pin_cmd = pin_ref;
                end
            end
            init_mrs: begin
                if (cnt == '0) begin
                    pin_cmd = pin_mrs;
                    a       = mode_word;
                end
            end
            activate: begin
                pin_cmd = pin_act;
                ba      = cur_bank;
                a       = cur_row;
            end
            write_burst, read_burst: begin
                if (cnt == '0) begin
                    pin_cmd = (state == write_burst) ? pin_wr : pin_rd;
                    ba      = cur_bank;
                    a       = col_word;
                end
            end
            refresh: begin
                if (cnt == '0) begin
                    pin_cmd = pin_ref;
                end
            end
            default: pin_cmd = pin_nop;
        endcase
    end

    assign {cs_n, ras_n, cas_n, we_n} = pin_cmd;
    assign cke = (state != init_wait);

    // fifo pop runs one cycle ahead of the word on dq
    assign w_fifo_rd = (state == rcd_wait && cnt == cnt_w'(1) && cmd_if.cmd == cmd_write) ||
                       (state == write_burst && cnt < cnt_w'(burst_len - 1));
    assign dq_oe     = (state == write_burst);
    assign r_fifo_wr = (state == read_burst) && (cnt >= cnt_w'(cas_lat));
    assign cmd_if.ack = (state == ack);

    act_after_init: assert property (@(posedge clk) disable iff (!rst_n)
        (pin_cmd == pin_act) |-> cmd_if.init_done);

    // bus stays released for the whole read return
    no_drive_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        (pin_cmd == pin_rd) |=> (!dq_oe) [*(cas_lat + burst_len)]);

endmodule

// File: design/sdram_2port_top.sv
`timescale 1ns/1ns

module sdram_2port_top #(
    parameter int frame_words    = 76800,
    parameter int fifo_depth     = 1024,
    parameter int init_cycles    = 20000,
    parameter int refresh_cycles = 780
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // system write side
    input  logic                             sys_w_valid,
    input  logic [sdram_fb_pkg::data_w-1:0]  sys_w_data,
    output logic [$clog2(fifo_depth+1)-1:0]  w_fifo_count,
    // system read side
    input  logic                             sys_r_req,
    output logic [sdram_fb_pkg::data_w-1:0]  sys_r_data,
    output logic [$clog2(fifo_depth+1)-1:0]  r_fifo_count,
    // sdram pins
    output logic                             sdram_clk,
    output logic                             sdram_cke,
    output logic                             sdram_cs_n,
    output logic                             sdram_ras_n,
    output logic                             sdram_cas_n,
    output logic                             sdram_we_n,
    output logic [sdram_fb_pkg::bank_w-1:0]  sdram_ba,
    output logic [sdram_fb_pkg::row_w-1:0]   sdram_addr,
    inout  wire  [sdram_fb_pkg::data_w-1:0]  sdram_dq
);
    import sdram_fb_pkg::*;

    localparam int cnt_w   = $clog2(fifo_depth + 1);
    localparam int off_w   = $bits(addr_t) - 1;
    localparam int rd_room = fifo_depth - 2 * burst_len;

    // offset of the last burst in a frame
    localparam logic [off_w-1:0] last_off = off_w'(frame_words - burst_len);

    logic              w_req;
    logic              r_req;
    addr_t             wr_addr;
    addr_t             write_addr;
    logic [off_w-1:0]  read_addr;
    logic              frame_sel;
    logic              read_enable;
    logic              req_ack;
    logic              ctrl_busy;
    logic              w_fifo_rd;
    logic              r_fifo_wr;
    logic              dq_oe;
    logic [data_w-1:0] w_fifo_rdata;
    logic [data_w-1:0] dq_out;

    sdram_cmd_if i_cmd_if ();

    assign sdram_clk = clk;

    // reads go to the frame not being filled
    assign wr_addr = w_req ? write_addr : {~frame_sel, read_addr};

    // ----------------------------------------------------------
    // dq bus
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (w_fifo_rd) begin
            dq_out <= w_fifo_rdata;
        end
    end

    assign sdram_dq = dq_oe ? dq_out : {data_w{1'bz}};

    // ----------------------------------------------------------
    // ping-pong addressing and burst scheduling
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_req       <= 1'b0;
            r_req       <= 1'b0;
            write_addr  <= '0;
            read_addr   <= '0;
            frame_sel   <= 1'b0;
            read_enable <= 1'b0;
        end else if (w_req) begin
            if (req_ack) begin
                w_req <= 1'b0;
                if (write_addr[off_w-1:0] == last_off) begin
                    // frame done, swap buffers
                    frame_sel   <= ~frame_sel;
                    write_addr  <= {~frame_sel, {off_w{1'b0}}};
                    read_enable <= 1'b1;
                end else begin
                    write_addr <= write_addr + addr_t'(burst_len);
                end
            end
        end else if (r_req) begin
            if (req_ack) begin
                r_req <= 1'b0;
                if (read_addr == last_off) begin
                    read_addr <= '0;
                end else begin
                    read_addr <= read_addr + off_w'(burst_len);
                end
            end
        end else if (!ctrl_busy) begin
            if (read_enable && r_fifo_count <= cnt_w'(rd_room)) begin
                r_req <= 1'b1;
            end else if (w_fifo_count >= cnt_w'(burst_len)) begin
                w_req <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // instances
    // ----------------------------------------------------------
    sdram_fifo #(
        .depth (fifo_depth)
    ) i_w_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (sys_w_valid),
        .wdata (sys_w_data),
        .rd    (w_fifo_rd),
        .rdata (w_fifo_rdata),
        .count (w_fifo_count)
    );

    sdram_fifo #(
        .depth (fifo_depth)
    ) i_r_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (r_fifo_wr),
        .wdata (sdram_dq),
        .rd    (sys_r_req),
        .rdata (sys_r_data),
        .count (r_fifo_count)
    );

    sdram_ctrl #(
        .refresh_cycles (refresh_cycles)
    ) i_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_req   (w_req),
        .r_req   (r_req),
        .wr_addr (wr_addr),
        .req_ack (req_ack),
        .busy    (ctrl_busy),
        .cmd_if  (i_cmd_if)
    );

    sdram_cmd #(
        .init_cycles (init_cycles)
    ) i_cmd (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_if    (i_cmd_if),
        .w_fifo_rd (w_fifo_rd),
        .r_fifo_wr (r_fifo_wr),
        .dq_oe     (dq_oe),
        .cke       (sdram_cke),
        .cs_n      (sdram_cs_n),
        .ras_n     (sdram_ras_n),
        .cas_n     (sdram_cas_n),
        .we_n      (sdram_we_n),
        .ba        (sdram_ba),
        .a         (sdram_addr)
    );

endmodule

// File: tests/sdram_model.sv
`timescale 1ns/1ns

module sdram_model (
    input  logic        clk,
    input  logic        cke,
    input  logic        cs_n,
    input  logic        ras_n,
    input  logic        cas_n,
    input  logic        we_n,
    input  logic [1:0]  ba,
    input  logic [11:0] addr,
    inout  wire  [15:0] dq
);

    // sparse storage keyed by {bank, row, col}
    logic [15:0] mem [int];
    logic [11:0] open_row [4];
    logic [15:0] rd_data;
    logic        rd_oe;
    int          wr_beat;
    int          rd_beat;
    int          wr_base;
    int          rd_base;

    assign dq = rd_oe ? rd_data : 16'bz;

    initial begin
        rd_oe   = 1'b0;
        rd_data = '0;
        wr_beat = -1;
        rd_beat = -1;
    end

    always @(posedge clk) begin
        logic [3:0] pins;
        pins = {cs_n, ras_n, cas_n, we_n};

        // ongoing write burst, one word per edge
        if (wr_beat >= 1) begin
            mem[wr_base + wr_beat] = dq;
            wr_beat = (wr_beat == 7) ? -1 : wr_beat + 1;
        end

        // read data lands cas latency 2 after the command
        if (rd_beat >= 0) begin
            rd_beat = rd_beat + 1;
            if (rd_beat <= 8) begin
                rd_oe <= 1'b1;
                if (mem.exists(rd_base + rd_beat - 1)) begin
                    rd_data <= mem[rd_base + rd_beat - 1];
                end else begin
                    rd_data <= 16'hxxxx;
                end
            end else begin
                rd_oe   <= 1'b0;
                rd_beat = -1;
            end
        end

        if (cke) begin
            case (pins)
                4'b0011: open_row[ba] = addr;
                4'b0100: begin
                    wr_base = {ba, open_row[ba], addr[7:0]};
                    mem[wr_base] = dq;
                    wr_beat = 1;
                end
                4'b0101: begin
                    rd_base = {ba, open_row[ba], addr[7:0]};
                    rd_beat = 0;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: tests/sdram_checker.sv
`timescale 1ns/1ns

module sdram_checker #(
    parameter int frame_words    = 128,
    parameter int fifo_depth     = 32,
    parameter int init_cycles    = 50,
    parameter int refresh_cycles = 200
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cke,
    input  logic        cs_n,
    input  logic        ras_n,
    input  logic        cas_n,
    input  logic        we_n,
    input  logic [1:0]  ba,
    input  logic [11:0] addr,
    input  logic        sys_r_req,
    input  logic [15:0] sys_r_data,
    input  int          r_count,
    input  int          w_count,
    output int          errors
);

    localparam int bursts_per_frame = frame_words / 8;

    logic [31:0] stim [0:4];
    logic        mrs_seen;
    int          cycle;
    int          up_cycles;
    int          mrs_cycle;
    int          last_ref;
    int          wr_bursts;
    int          popped;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // word k of a frame is the upper half of the (k+1)th lcg state
    function automatic logic [15:0] frame_word(input logic [31:0] seed, input int k);
        logic [31:0] s;
        s = seed;
        for (int i = 0; i <= k; i++) begin
            s = lcg_step(s);
        end
        return s[31:16];
    endfunction

    initial begin
        $readmemh("tests/sdram_stim.txt", stim);
        errors    = 0;
        mrs_seen  = 1'b0;
        cycle     = 0;
        up_cycles = 0;
        mrs_cycle = 0;
        last_ref  = -1;
        wr_bursts = 0;
        popped    = 0;
    end

    always @(posedge clk) begin
        logic [3:0]  pins;
        logic [15:0] exp_word;
        logic        exp_cke;
        int          done;
        int          k;
        logic        hit;
        pins = {cs_n, ras_n, cas_n, we_n};
        done = wr_bursts / bursts_per_frame;
        cycle++;
        if (rst_n) begin
            // cke held low through the power-up wait
            up_cycles++;
            exp_cke = (up_cycles > init_cycles);
            if (cke !== exp_cke) begin
                $display("Mismatch at %0t: sdram_cke expected %0b, got %0b",
                         $time, exp_cke, cke);
                errors++;
            end

            // ------------------------------------------------------------
            // init order and mode word
            // ------------------------------------------------------------
            if (!mrs_seen && !cs_n && pins != 4'b0111 && pins != 4'b0010 &&
                pins != 4'b0001 && pins != 4'b0000) begin
                $display("Error at %0t: command %b issued before the mode load", $time, pins);
                errors++;
            end
            if (pins == 4'b0000) begin
                mrs_seen  = 1'b1;
                mrs_cycle = cycle;
                if (addr[2:0] != 3'b011 || addr[6:4] != 3'd2) begin
                    $display({"Mismatch at %0t: sdram_addr mode word expected burst code 3 ",
                              "cas 2, got burst code %0d cas %0d"},
                             $time, addr[2:0], addr[6:4]);
                    errors++;
                end
            end

            // refresh spacing after init
            if (last_ref >= 0 && cycle - last_ref == refresh_cycles + 17) begin
                $display("Error at %0t: no auto-refresh for more than %0d cycles",
                         $time, refresh_cycles + 16);
                errors++;
            end
            // the first refresh after init must come at all
            if (mrs_seen && last_ref < 0 && cycle - mrs_cycle == 2 * refresh_cycles) begin
                $display("Error at %0t: no auto-refresh after init", $time);
                errors++;
            end
            if (pins == 4'b0001 && mrs_seen) begin
                last_ref = cycle;
            end

            // ping-pong banks
            if (pins == 4'b0100) begin
                if (ba[1] != done[0]) begin
                    $display("Mismatch at %0t: sdram_ba[1] on write expected %0d, got %0d",
                             $time, done[0], ba[1]);
                    errors++;
                end
                wr_bursts++;
            end
            if (pins == 4'b0101 && ba[1] == done[0]) begin
                $display("Mismatch at %0t: sdram_ba[1] on read expected %0d, got %0d",
                         $time, !done[0], ba[1]);
                errors++;
            end

            // no reads before frame 0 is written and counts stay bounded
            if (r_count != 0 && done == 0) begin
                $display("Error at %0t: read FIFO filled before frame 0 was complete", $time);
                errors++;
            end
            if (r_count > fifo_depth || w_count > fifo_depth) begin
                $display("Error at %0t: FIFO count above depth (w %0d, r %0d)",
                         $time, w_count, r_count);
                errors++;
            end

            // read data against any completed frame
            if (sys_r_req) begin
                k   = popped % frame_words;
                hit = 1'b0;
                for (int f = 0; f < done; f++) begin
                    if (frame_word(stim[2 + f], k) == sys_r_data) begin
                        hit = 1'b1;
                    end
                end
                if (!hit) begin
                    exp_word = (done > 0) ? frame_word(stim[1 + done], k) : 16'hxxxx;
                    $display("Mismatch at %0t: sys_r_data expected %h, got %h",
                             $time, exp_word, sys_r_data);
                    errors++;
                end
                popped++;
            end
        end
    end

endmodule

// File: tests/tb_sdram_2port.sv
`timescale 1ns/1ns

module tb_sdram_2port;

    localparam int frame_words    = 128;
    localparam int fifo_depth     = 32;
    localparam int init_cycles    = 50;
    localparam int refresh_cycles = 200;
    localparam int cnt_w          = $clog2(fifo_depth + 1);

    logic             clk;
    logic             rst_n;
    logic             sys_w_valid;
    logic [15:0]      sys_w_data;
    logic [cnt_w-1:0] w_fifo_count;
    logic             sys_r_req;
    logic [15:0]      sys_r_data;
    logic [cnt_w-1:0] r_fifo_count;
    logic             sdram_clk;
    logic             sdram_cke;
    logic             sdram_cs_n;
    logic             sdram_ras_n;
    logic             sdram_cas_n;
    logic             sdram_we_n;
    logic [1:0]       sdram_ba;
    logic [11:0]      sdram_addr;
    wire  [15:0]      sdram_dq;
    int               errors;
    logic [31:0]      stim [0:4];
    logic             stim_loaded;

    always #4 clk = ~clk;

    sdram_2port_top #(
        .frame_words    (frame_words),
        .fifo_depth     (fifo_depth),
        .init_cycles    (init_cycles),
        .refresh_cycles (refresh_cycles)
    ) i_sdram_2port_top (
        .clk (clk), .rst_n (rst_n),
        .sys_w_valid (sys_w_valid), .sys_w_data (sys_w_data), .w_fifo_count (w_fifo_count),
        .sys_r_req (sys_r_req), .sys_r_data (sys_r_data), .r_fifo_count (r_fifo_count),
        .sdram_clk (sdram_clk), .sdram_cke (sdram_cke), .sdram_cs_n (sdram_cs_n),
        .sdram_ras_n (sdram_ras_n), .sdram_cas_n (sdram_cas_n), .sdram_we_n (sdram_we_n),
        .sdram_ba (sdram_ba), .sdram_addr (sdram_addr), .sdram_dq (sdram_dq)
    );

    sdram_model i_model (
        .clk (sdram_clk), .cke (sdram_cke), .cs_n (sdram_cs_n), .ras_n (sdram_ras_n),
        .cas_n (sdram_cas_n), .we_n (sdram_we_n), .ba (sdram_ba), .addr (sdram_addr),
        .dq (sdram_dq)
    );

    sdram_checker #(
        .frame_words (frame_words), .fifo_depth (fifo_depth),
        .init_cycles (init_cycles), .refresh_cycles (refresh_cycles)
    ) i_checker (
        .clk (clk), .rst_n (rst_n), .cke (sdram_cke), .cs_n (sdram_cs_n),
        .ras_n (sdram_ras_n), .cas_n (sdram_cas_n), .we_n (sdram_we_n),
        .ba (sdram_ba), .addr (sdram_addr),
        .sys_r_req (sys_r_req), .sys_r_data (sys_r_data),
        .r_count (int'(r_fifo_count)), .w_count (int'(w_fifo_count)), .errors (errors)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // one frame of lcg words, held back while the write FIFO is near full
    task automatic write_frame(input logic [31:0] seed);
        logic [31:0] s;
        int          k;
        s = seed;
        k = 0;
        while (k < frame_words) begin
            @(posedge clk);
            if (w_fifo_count < cnt_w'(fifo_depth - 4)) begin
                s = next_rand(s);
                sys_w_valid <= 1'b1;
                sys_w_data  <= s[31:16];
                k++;
            end else begin
                sys_w_valid <= 1'b0;
            end
        end
        @(posedge clk);
        sys_w_valid <= 1'b0;
    endtask

    task automatic drain_reads(input int n_words);
        int popped;
        popped = 0;
        while (popped < n_words) begin
            @(posedge clk);
            if (sys_r_req ? (r_fifo_count >= 2) : (r_fifo_count >= 1)) begin
                sys_r_req <= 1'b1;
                popped++;
            end else begin
                sys_r_req <= 1'b0;
            end
        end
        @(posedge clk);
        sys_r_req <= 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        sys_w_valid = 1'b0;
        sys_w_data  = '0;
        sys_r_req   = 1'b0;
        stim_loaded = 1'b0;
        $readmemh("tests/sdram_stim.txt", stim);
        stim_loaded = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int f = 0; f < stim[0] && f < 3; f++) begin
            write_frame(stim[2 + f]);
        end
        drain_reads(stim[1]);
        repeat (20) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        int limit;
        wait (stim_loaded);
        limit = stim[0] * frame_words * 40 + init_cycles;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: tests/sdram_stim.txt
// line 1 frame count (at most 3), line 2 words to read
// then one 32 bit lcg seed per frame, all hex
00000003
00000200
0000143b
0badc0de
13579bdf

// File: filelist.f
design/sdram_fb_pkg.sv
design/sdram_cmd_if.sv
design/sdram_fifo.sv
design/sdram_ctrl.sv
design/sdram_cmd.sv
design/sdram_2port_top.sv
tests/sdram_model.sv
tests/sdram_checker.sv
tests/tb_sdram_2port.sv

// File: Bender.yml
package:
  name: sdram_2port

sources:
  - design/sdram_fb_pkg.sv
  - design/sdram_cmd_if.sv
  - design/sdram_fifo.sv
  - design/sdram_ctrl.sv
  - design/sdram_cmd.sv
  - design/sdram_2port_top.sv
  - target: test
    files:
      - tests/sdram_model.sv
      - tests/sdram_checker.sv
      - tests/tb_sdram_2port.sv
